// ==== logic/bypass_data.sv ====
// bypass data path
// registers the lsu result, keeps a captured copy for loads that
// stalled decode, and builds the register and csr forwarding muxes

`timescale 1ns/100ps

module bypass_data (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        lsu_valid_i,
	input  logic [hazard_pkg::XLEN-1:0] lsu_reg_wdata_i,
	input  logic                        lsu_mem_to_reg_i,
	input  logic                        lsu_conflict_i,
	input  logic                        capture_i,
	input  logic                        live_sel_i,
	input  logic                        exu_csr_conflict_i,
	input  logic                        lsu_csr_conflict_i,
	wb_stage_if.dst                     exu_i,
	wb_stage_if.dst                     lsu_i,
	output logic                        lsu_valid_q_o,
	output logic [hazard_pkg::XLEN-1:0] reg_bypass_o,
	output logic [hazard_pkg::XLEN-1:0] csr_bypass_o
);

	logic [hazard_pkg::XLEN-1:0] lsu_data_q;
	logic [hazard_pkg::XLEN-1:0] captured_q;
	logic                        use_live;

	// lsu pipeline register
	always_ff @(posedge clock) begin
		if (reset) begin
			lsu_valid_q_o <= 1'b0;
		end else begin
			lsu_valid_q_o <= lsu_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		lsu_data_q <= lsu_reg_wdata_i;
	end

	// copy kept for decode once the wait ends
	always_ff @(posedge clock) begin
		if (reset) begin
			captured_q <= '0;
		end else if (capture_i) begin
			captured_q <= lsu_data_q;
		end
	end

	// non-load results are already final in the lsu register
	assign use_live     = (lsu_conflict_i & ~lsu_mem_to_reg_i) | live_sel_i;
	assign reg_bypass_o = use_live ? lsu_data_q : captured_q;

	// exu holds the younger csr write, so it wins
	assign csr_bypass_o = exu_csr_conflict_i ? exu_i.csr_wdata :
		lsu_csr_conflict_i ? lsu_i.csr_wdata : '0;

	// a csr conflict needs a writing csr kind in the stage it came from
	a_csr_src_writes: assert property (@(posedge clock) disable iff (reset)
		(exu_csr_conflict_i || lsu_csr_conflict_i) |->
		((exu_csr_conflict_i && hazard_pkg::csr_writes(exu_i.csr_type))
		|| (lsu_csr_conflict_i && hazard_pkg::csr_writes(lsu_i.csr_type))))
		else $error("csr bypass taken from a stage that does not write");

endmodule

// ==== logic/hazard_if.sv ====
// hazard unit interfaces
// read_req_if carries the decode register and csr reads,
// wb_stage_if carries one stage's pending register and csr writes

`timescale 1ns/100ps

interface read_req_if (
	input logic clock
);

	logic                          busy;
	logic                          ren0;
	logic                          ren1;
	logic [hazard_pkg::REG_AW-1:0] rsc0;
	logic [hazard_pkg::REG_AW-1:0] rsc1;
	logic                          csr_ren;
	logic [hazard_pkg::CSR_AW-1:0] csr_raddr;

	modport src (output busy, ren0, ren1, rsc0, rsc1, csr_ren, csr_raddr);

	// the clock is there for the checks on the receiving side
	modport dst (input clock, busy, ren0, ren1, rsc0, rsc1, csr_ren, csr_raddr);

endinterface

interface wb_stage_if;

	logic                          wd;
	logic [hazard_pkg::REG_AW-1:0] wreg;
	logic [hazard_pkg::CSR_AW-1:0] csr_waddr;
	hazard_pkg::csr_op_t           csr_type;
	logic [hazard_pkg::XLEN-1:0]   csr_wdata;
	logic                          ready;

	modport src (output wd, wreg, csr_waddr, csr_type, csr_wdata, ready);

	modport dst (input wd, wreg, csr_waddr, csr_type, csr_wdata, ready);

endinterface

// ==== logic/hazard_pkg.sv ====
// hazard package
// widths, csr operation kinds and stall states shared by the
// operand hazard unit, plus the csr write-enable decode

package hazard_pkg;

	// data and address widths
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;
	localparam int CSR_AW = 12;

	// performance counter width
	localparam int PERF_W = 16;

	// csr operation kinds carried down the pipeline
	typedef enum logic [2:0] {
		CSR_NONE  = 3'd0,
		CSR_CSRRW = 3'd1,
		CSR_CSRRS = 3'd2,
		CSR_CSRRC = 3'd3,
		CSR_ECALL = 3'd4,
		CSR_MRET  = 3'd5
	} csr_op_t;

	// decode stall states
	typedef enum logic {
		ST_RUN      = 1'b0,
		ST_WAIT_LSU = 1'b1
	} stall_state_t;

	// csrrc and mret are not treated as csr writers here
	function automatic logic csr_writes(csr_op_t op);
		return (op == CSR_CSRRW) || (op == CSR_CSRRS) || (op == CSR_ECALL);
	endfunction

endpackage

// ==== logic/hazard_top.sv ====
// operand hazard unit
// flags decode reads that collide with pending exu/lsu writes,
// stalls decode on outstanding loads and forwards register and csr data

`timescale 1ns/100ps

module hazard_top (
	input  logic                          clock,
	input  logic                          reset,
	// decode reads
	input  logic [hazard_pkg::CSR_AW-1:0] idu_csr_raddr_i,
	input  logic                          idu_csr_ren_i,
	input  logic                          idu_busy_i,
	input  logic                          idu_ren0_i,
	input  logic                          idu_ren1_i,
	input  logic [hazard_pkg::REG_AW-1:0] idu_rsc0_i,
	input  logic [hazard_pkg::REG_AW-1:0] idu_rsc1_i,
	// exu pending writes
	input  logic [hazard_pkg::CSR_AW-1:0] exu_csr_waddr_i,
	input  logic [2:0]                    exu_csr_type_i,
	input  logic [hazard_pkg::XLEN-1:0]   exu_csr_wdata_i,
	input  logic                          exu_ready_i,
	input  logic                          exu_wd_i,
	input  logic [hazard_pkg::REG_AW-1:0] exu_wreg_i,
	// lsu pending writes
	input  logic [hazard_pkg::CSR_AW-1:0] lsu_csr_waddr_i,
	input  logic [2:0]                    lsu_csr_type_i,
	input  logic [hazard_pkg::XLEN-1:0]   lsu_csr_wdata_i,
	input  logic                          lsu_ready_i,
	input  logic                          lsu_mem_to_reg_i,
	input  logic                          lsu_wd_i,
	input  logic                          lsu_valid_i,
	input  logic [hazard_pkg::REG_AW-1:0] lsu_wreg_i,
	input  logic [hazard_pkg::XLEN-1:0]   lsu_reg_wdata_i,
	// hazard results
	output logic                          conflict_reg0_o,
	output logic                          conflict_reg1_o,
	output logic                          conflict_csr_o,
	output logic                          conflict_id_nop_o,
	output logic [hazard_pkg::XLEN-1:0]   conflict_reg_bypass_data_o,
	output logic [hazard_pkg::XLEN-1:0]   conflict_csr_bypass_data_o,
	output logic [hazard_pkg::PERF_W-1:0] stall_events_o,
	output logic [hazard_pkg::PERF_W-1:0] stall_cycles_o
);

	logic lsu_valid_q;
	logic exu_conflict;
	logic lsu_conflict;
	logic exu_csr_conflict;
	logic lsu_csr_conflict;
	logic capture;
	logic live_sel;
	logic enter_wait;
	logic waiting;

	read_req_if rd_if (.clock(clock));
	wb_stage_if exu_if ();
	wb_stage_if lsu_if ();

	assign rd_if.busy      = idu_busy_i;
	assign rd_if.ren0      = idu_ren0_i;
	assign rd_if.ren1      = idu_ren1_i;
	assign rd_if.rsc0      = idu_rsc0_i;
	assign rd_if.rsc1      = idu_rsc1_i;
	assign rd_if.csr_ren   = idu_csr_ren_i;
	assign rd_if.csr_raddr = idu_csr_raddr_i;

	assign exu_if.wd        = exu_wd_i;
	assign exu_if.wreg      = exu_wreg_i;
	assign exu_if.csr_waddr = exu_csr_waddr_i;
	assign exu_if.csr_type  = hazard_pkg::csr_op_t'(exu_csr_type_i);
	assign exu_if.csr_wdata = exu_csr_wdata_i;
	assign exu_if.ready     = exu_ready_i;

	assign lsu_if.wd        = lsu_wd_i;
	assign lsu_if.wreg      = lsu_wreg_i;
	assign lsu_if.csr_waddr = lsu_csr_waddr_i;
	assign lsu_if.csr_type  = hazard_pkg::csr_op_t'(lsu_csr_type_i);
	assign lsu_if.csr_wdata = lsu_csr_wdata_i;
	assign lsu_if.ready     = lsu_ready_i;

	raw_detect u_raw_detect (
		.rd_i               (rd_if),
		.exu_i              (exu_if),
		.lsu_i              (lsu_if),
		.lsu_valid_q_i      (lsu_valid_q),
		.conflict_reg0_o    (conflict_reg0_o),
		.conflict_reg1_o    (conflict_reg1_o),
		.exu_conflict_o     (exu_conflict),
		.lsu_conflict_o     (lsu_conflict),
		.exu_csr_conflict_o (exu_csr_conflict),
		.lsu_csr_conflict_o (lsu_csr_conflict)
	);

	stall_fsm u_stall_fsm (
		.clock          (clock),
		.reset          (reset),
		.exu_conflict_i (exu_conflict),
		.lsu_conflict_i (lsu_conflict),
		.lsu_valid_q_i  (lsu_valid_q),
		.nop_o          (conflict_id_nop_o),
		.capture_o      (capture),
		.live_sel_o     (live_sel),
		.enter_wait_o   (enter_wait),
		.waiting_o      (waiting)
	);

	stall_counter u_stall_counter (
		.clock          (clock),
		.reset          (reset),
		.enter_wait_i   (enter_wait),
		.waiting_i      (waiting),
		.stall_events_o (stall_events_o),
		.stall_cycles_o (stall_cycles_o)
	);

	bypass_data u_bypass_data (
		.clock              (clock),
		.reset              (reset),
		.lsu_valid_i        (lsu_valid_i),
		.lsu_reg_wdata_i    (lsu_reg_wdata_i),
		.lsu_mem_to_reg_i   (lsu_mem_to_reg_i),
		.lsu_conflict_i     (lsu_conflict),
		.capture_i          (capture),
		.live_sel_i         (live_sel),
		.exu_csr_conflict_i (exu_csr_conflict),
		.lsu_csr_conflict_i (lsu_csr_conflict),
		.exu_i              (exu_if),
		.lsu_i              (lsu_if),
		.lsu_valid_q_o      (lsu_valid_q),
		.reg_bypass_o       (conflict_reg_bypass_data_o),
		.csr_bypass_o       (conflict_csr_bypass_data_o)
	);

	// either stage's csr write blocks the read
	assign conflict_csr_o = exu_csr_conflict | lsu_csr_conflict;

endmodule

// ==== logic/raw_detect.sv ====
// read-after-write detection
// compares the decode register and csr reads against the pending
// writes of the exu and lsu stages and reports the conflict levels

`timescale 1ns/100ps

module raw_detect (
	read_req_if.dst rd_i,
	wb_stage_if.dst exu_i,
	wb_stage_if.dst lsu_i,
	input  logic    lsu_valid_q_i,
	output logic    conflict_reg0_o,
	output logic    conflict_reg1_o,
	output logic    exu_conflict_o,
	output logic    lsu_conflict_o,
	output logic    exu_csr_conflict_o,
	output logic    lsu_csr_conflict_o
);

	logic [hazard_pkg::REG_AW-1:0] rd0_addr;
	logic [hazard_pkg::REG_AW-1:0] rd1_addr;
	logic [hazard_pkg::REG_AW-1:0] exu_addr;
	logic [hazard_pkg::REG_AW-1:0] lsu_addr;
	logic                          rd0_live;
	logic                          rd1_live;
	logic                          exu_busy;
	logic                          lsu_busy;
	logic                          exu_hit0;
	logic                          exu_hit1;
	logic                          lsu_hit0;
	logic                          lsu_hit1;

	// disabled ports collapse to x0
	assign rd0_addr = {hazard_pkg::REG_AW{rd_i.ren0}} & rd_i.rsc0;
	assign rd1_addr = {hazard_pkg::REG_AW{rd_i.ren1}} & rd_i.rsc1;
	assign exu_addr = {hazard_pkg::REG_AW{exu_i.wd}} & exu_i.wreg;
	assign lsu_addr = {hazard_pkg::REG_AW{lsu_i.wd}} & lsu_i.wreg;

	// x0 never conflicts
	assign rd0_live = (rd0_addr != '0);
	assign rd1_live = (rd1_addr != '0);

	// lsu also counts as busy while its result sits in the pipeline register
	assign exu_busy = ~exu_i.ready;
	assign lsu_busy = ~lsu_i.ready | lsu_valid_q_i;

	assign exu_hit0 = rd_i.busy & exu_busy & rd0_live & (rd0_addr == exu_addr);
	assign exu_hit1 = rd_i.busy & exu_busy & rd1_live & (rd1_addr == exu_addr);
	assign lsu_hit0 = rd_i.busy & lsu_busy & rd0_live & (rd0_addr == lsu_addr);
	assign lsu_hit1 = rd_i.busy & lsu_busy & rd1_live & (rd1_addr == lsu_addr);

	assign conflict_reg0_o = exu_hit0 | lsu_hit0;
	assign conflict_reg1_o = exu_hit1 | lsu_hit1;
	assign exu_conflict_o  = exu_hit0 | exu_hit1;
	assign lsu_conflict_o  = lsu_hit0 | lsu_hit1;

	// csr reads only clash with kinds that really write
	assign exu_csr_conflict_o = rd_i.busy & rd_i.csr_ren & exu_busy
		& hazard_pkg::csr_writes(exu_i.csr_type)
		& (rd_i.csr_raddr == exu_i.csr_waddr);
	assign lsu_csr_conflict_o = rd_i.busy & rd_i.csr_ren & lsu_busy
		& hazard_pkg::csr_writes(lsu_i.csr_type)
		& (rd_i.csr_raddr == lsu_i.csr_waddr);

	// kinds past mret would quietly decode as non-writing
	a_csr_type_legal: assert property (@(posedge rd_i.clock)
		(exu_i.csr_type <= hazard_pkg::CSR_MRET) && (lsu_i.csr_type <= hazard_pkg::CSR_MRET))
		else $error("undefined csr operation kind on a pending write");

endmodule

// ==== logic/stall_counter.sv ====
// stall statistics
// counts stall events and the cycles spent waiting on the lsu,
// both counters wrap

`timescale 1ns/100ps

module stall_counter (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          enter_wait_i,
	input  logic                          waiting_i,
	output logic [hazard_pkg::PERF_W-1:0] stall_events_o,
	output logic [hazard_pkg::PERF_W-1:0] stall_cycles_o
);

	logic [hazard_pkg::PERF_W-1:0] events_q;
	logic [hazard_pkg::PERF_W-1:0] cycles_q;

	// one event per run to wait transition
	always_ff @(posedge clock) begin
		if (reset) begin
			events_q <= '0;
		end else if (enter_wait_i) begin
			events_q <= events_q + 1'b1;
		end
	end

	// every cycle heading into the wait state
	always_ff @(posedge clock) begin
		if (reset) begin
			cycles_q <= '0;
		end else if (waiting_i) begin
			cycles_q <= cycles_q + 1'b1;
		end
	end

	assign stall_events_o = events_q;
	assign stall_cycles_o = cycles_q;

endmodule

// ==== logic/stall_fsm.sv ====
// decode stall control
// holds decode with a nop while an lsu result is outstanding and
// steers capture and selection of the forwarded lsu data

`timescale 1ns/100ps

module stall_fsm (
	input  logic clock,
	input  logic reset,
	input  logic exu_conflict_i,
	input  logic lsu_conflict_i,
	input  logic lsu_valid_q_i,
	output logic nop_o,
	output logic capture_o,
	output logic live_sel_o,
	output logic enter_wait_o,
	output logic waiting_o
);

	hazard_pkg::stall_state_t state_q;
	hazard_pkg::stall_state_t state_d;
	logic                     nop_q;
	logic                     run_stall;
	logic                     in_run;

	assign in_run = (state_q == hazard_pkg::ST_RUN);

	// exu results cannot be forwarded yet, lsu only once registered
	assign run_stall = exu_conflict_i | (lsu_conflict_i & ~lsu_valid_q_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			hazard_pkg::ST_RUN: begin
				if (lsu_conflict_i && !lsu_valid_q_i) begin
					state_d = hazard_pkg::ST_WAIT_LSU;
				end
			end
			hazard_pkg::ST_WAIT_LSU: begin
				if (lsu_valid_q_i) begin
					state_d = hazard_pkg::ST_RUN;
				end
			end
			default: state_d = hazard_pkg::ST_RUN;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= hazard_pkg::ST_RUN;
			nop_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			// held across the whole wait, dropped with the return to run
			if (enter_wait_o) begin
				nop_q <= 1'b1;
			end else if (!in_run && lsu_valid_q_i) begin
				nop_q <= 1'b0;
			end
		end
	end

	assign nop_o        = in_run ? run_stall : nop_q;
	assign live_sel_o   = in_run & lsu_conflict_i;
	assign capture_o    = lsu_valid_q_i & (~in_run | lsu_conflict_i);
	assign enter_wait_o = in_run & (state_d == hazard_pkg::ST_WAIT_LSU);
	assign waiting_o    = (state_d == hazard_pkg::ST_WAIT_LSU);

	// the registered nop must cover every cycle of the wait
	a_wait_holds_nop: assert property (@(posedge clock) disable iff (reset)
		!in_run |-> nop_o)
		else $error("decode not held while waiting on the lsu result");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the hazard unit testbench with Verilator and runs it
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module hazard_tb -o hazard_sim

./obj_dir/hazard_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi

// ==== tb.f ====
logic/hazard_pkg.sv
logic/hazard_if.sv
logic/raw_detect.sv
logic/stall_fsm.sv
logic/stall_counter.sv
logic/bypass_data.sv
logic/hazard_top.sv
tests/hazard_checker.sv
tests/hazard_tb.sv

// ==== tests/hazard_checker.sv ====
// hazard unit checker
// reference model of the operand hazard rules, compared against
// every DUT output at each rising clock edge outside reset

`timescale 1ns/100ps

module hazard_checker (
	input logic                          clock,
	input logic                          reset,
	input logic                          idu_busy_i, idu_ren0_i, idu_ren1_i, idu_csr_ren_i,
	input logic [hazard_pkg::REG_AW-1:0] idu_rsc0_i, idu_rsc1_i, exu_wreg_i, lsu_wreg_i,
	input logic [hazard_pkg::CSR_AW-1:0] idu_csr_raddr_i, exu_csr_waddr_i, lsu_csr_waddr_i,
	input logic [2:0]                    exu_csr_type_i, lsu_csr_type_i,
	input logic [hazard_pkg::XLEN-1:0]   exu_csr_wdata_i, lsu_csr_wdata_i, lsu_reg_wdata_i,
	input logic                          exu_wd_i, exu_ready_i, lsu_wd_i, lsu_ready_i,
	input logic                          lsu_valid_i, lsu_mem_to_reg_i,
	input logic                          conflict_reg0_o, conflict_reg1_o,
	input logic                          conflict_csr_o, conflict_id_nop_o,
	input logic [hazard_pkg::XLEN-1:0]   conflict_reg_bypass_data_o,
	input logic [hazard_pkg::XLEN-1:0]   conflict_csr_bypass_data_o,
	input logic [hazard_pkg::PERF_W-1:0] stall_events_o, stall_cycles_o
);

	int                            errors = 0;
	int                            checks = 0;
	logic                          model_wait;
	logic                          model_valid_q;
	logic [hazard_pkg::XLEN-1:0]   model_data_q;
	logic [hazard_pkg::XLEN-1:0]   model_captured;
	logic [hazard_pkg::PERF_W-1:0] model_events;
	logic [hazard_pkg::PERF_W-1:0] model_cycles;
	logic                          e0, e1, l0, l1, ecsr, lcsr;
	logic                          econf, lconf, nop_exp, live, grab, next_wait;
	logic [hazard_pkg::XLEN-1:0]   reg_exp;
	logic [hazard_pkg::XLEN-1:0]   csr_exp;

	// only csrrw, csrrs and ecall write a csr
	function automatic logic writes_csr(input logic [2:0] op);
		return (op == hazard_pkg::CSR_CSRRW) || (op == hazard_pkg::CSR_CSRRS)
			|| (op == hazard_pkg::CSR_ECALL);
	endfunction

	function automatic logic reg_hit(input logic ren, input logic [4:0] ra, input logic wen,
		input logic [4:0] wa, input logic stage_busy);
		return idu_busy_i && stage_busy && ren && wen && (ra != 5'd0) && (ra == wa);
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			model_wait     = 1'b0;
			model_valid_q  = 1'b0;
			model_captured = '0;
			model_events   = '0;
			model_cycles   = '0;
		end else begin
			// lsu stays busy while its registered result is pending
			e0   = reg_hit(idu_ren0_i, idu_rsc0_i, exu_wd_i, exu_wreg_i, !exu_ready_i);
			e1   = reg_hit(idu_ren1_i, idu_rsc1_i, exu_wd_i, exu_wreg_i, !exu_ready_i);
			l0   = reg_hit(idu_ren0_i, idu_rsc0_i, lsu_wd_i, lsu_wreg_i, !lsu_ready_i || model_valid_q);
			l1   = reg_hit(idu_ren1_i, idu_rsc1_i, lsu_wd_i, lsu_wreg_i, !lsu_ready_i || model_valid_q);
			ecsr = idu_busy_i && idu_csr_ren_i && !exu_ready_i && writes_csr(exu_csr_type_i)
				&& (idu_csr_raddr_i == exu_csr_waddr_i);
			lcsr = idu_busy_i && idu_csr_ren_i && (!lsu_ready_i || model_valid_q)
				&& writes_csr(lsu_csr_type_i) && (idu_csr_raddr_i == lsu_csr_waddr_i);
			econf     = e0 || e1;
			lconf     = l0 || l1;
			nop_exp   = model_wait ? 1'b1 : (econf || (lconf && !model_valid_q));
			live      = !model_wait && lconf;
			grab      = model_valid_q && (model_wait || lconf);
			next_wait = model_wait ? !model_valid_q : (lconf && !model_valid_q);
			reg_exp   = ((lconf && !lsu_mem_to_reg_i) || live) ? model_data_q : model_captured;
			csr_exp   = ecsr ? exu_csr_wdata_i : (lcsr ? lsu_csr_wdata_i : '0);
			compare("conflict_reg0_o", conflict_reg0_o, e0 || l0);
			compare("conflict_reg1_o", conflict_reg1_o, e1 || l1);
			compare("conflict_csr_o", conflict_csr_o, ecsr || lcsr);
			compare("conflict_id_nop_o", conflict_id_nop_o, nop_exp);
			compare("conflict_reg_bypass_data_o", conflict_reg_bypass_data_o, reg_exp);
			compare("conflict_csr_bypass_data_o", conflict_csr_bypass_data_o, csr_exp);
			compare("stall_events_o", stall_events_o, model_events);
			compare("stall_cycles_o", stall_cycles_o, model_cycles);
			if (grab) model_captured = model_data_q;
			if (!model_wait && next_wait) model_events = model_events + 1'b1;
			if (next_wait) model_cycles = model_cycles + 1'b1;
			model_wait    = next_wait;
			model_valid_q = lsu_valid_i;
		end
		// the lsu data register loads every cycle, reset or not
		model_data_q = lsu_reg_wdata_i;
	end

endmodule

// ==== tests/hazard_tb.sv ====
// operand hazard unit testbench
// drives seeded random decode reads and stage writes on the falling
// edge and runs the tests in order, the checker does the comparing

`timescale 1ns/100ps

module hazard_tb;

	localparam int RESET_CYCLES = 5;
	localparam int REG_CYCLES   = 400;
	localparam int CSR_CYCLES   = 300;
	localparam int LOAD_CYCLES  = 300;
	localparam int FWD_CYCLES   = 200;
	localparam int STAT_CYCLES  = 400;
	localparam int TIMEOUT      = RESET_CYCLES + REG_CYCLES + CSR_CYCLES + LOAD_CYCLES
		+ FWD_CYCLES + STAT_CYCLES + 100;

	logic                          clock, reset;
	logic                          idu_busy_i, idu_ren0_i, idu_ren1_i, idu_csr_ren_i;
	logic [hazard_pkg::REG_AW-1:0] idu_rsc0_i, idu_rsc1_i, exu_wreg_i, lsu_wreg_i;
	logic [hazard_pkg::CSR_AW-1:0] idu_csr_raddr_i, exu_csr_waddr_i, lsu_csr_waddr_i;
	logic [2:0]                    exu_csr_type_i, lsu_csr_type_i;
	logic [hazard_pkg::XLEN-1:0]   exu_csr_wdata_i, lsu_csr_wdata_i, lsu_reg_wdata_i;
	logic                          exu_wd_i, exu_ready_i, lsu_wd_i, lsu_ready_i;
	logic                          lsu_valid_i, lsu_mem_to_reg_i;
	logic                          conflict_reg0_o, conflict_reg1_o;
	logic                          conflict_csr_o, conflict_id_nop_o;
	logic [hazard_pkg::XLEN-1:0]   conflict_reg_bypass_data_o, conflict_csr_bypass_data_o;
	logic [hazard_pkg::PERF_W-1:0] stall_events_o, stall_cycles_o;
	integer                        seed;
	int                            tb_errors;
	int                            total;
	int                            cycle_count = 0;

	hazard_top UUT (.*);

	hazard_checker u_checker (.*);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic clear_inputs();
		{idu_busy_i, idu_ren0_i, idu_ren1_i, idu_csr_ren_i, idu_rsc0_i, idu_rsc1_i} = '0;
		{idu_csr_raddr_i, exu_wd_i, exu_wreg_i, exu_csr_waddr_i, exu_csr_type_i} = '0;
		{exu_csr_wdata_i, exu_ready_i, lsu_wd_i, lsu_wreg_i, lsu_csr_waddr_i} = '0;
		{lsu_csr_type_i, lsu_csr_wdata_i, lsu_ready_i, lsu_valid_i} = '0;
		{lsu_mem_to_reg_i, lsu_reg_wdata_i} = '0;
	endtask

	// small address pools keep collisions frequent
	task automatic drive_inputs(input int mode);
		idu_busy_i       = 2'($random(seed)) != 2'd0;
		idu_ren0_i       = 1'($random(seed));
		idu_ren1_i       = 1'($random(seed));
		idu_rsc0_i       = 5'($random(seed) & 3);
		idu_rsc1_i       = 5'($random(seed) & 3);
		idu_csr_ren_i    = (mode == 2) || 1'($random(seed));
		idu_csr_raddr_i  = 12'h300 | 12'($random(seed) & 1);
		exu_wd_i         = 1'($random(seed));
		exu_wreg_i       = 5'($random(seed) & 3);
		exu_csr_waddr_i  = 12'h300 | 12'($random(seed) & 1);
		exu_csr_type_i   = 3'({$random(seed)} % 6);
		exu_csr_wdata_i  = $random(seed);
		exu_ready_i      = 1'($random(seed));
		lsu_wd_i         = 1'($random(seed));
		lsu_wreg_i       = 5'($random(seed) & 3);
		lsu_csr_waddr_i  = 12'h300 | 12'($random(seed) & 1);
		lsu_csr_type_i   = 3'({$random(seed)} % 6);
		lsu_csr_wdata_i  = $random(seed);
		lsu_ready_i      = 1'($random(seed));
		lsu_valid_i      = 1'($random(seed));
		lsu_mem_to_reg_i = 1'($random(seed));
		lsu_reg_wdata_i  = $random(seed);
		// load wait and forwarding focus on the lsu path
		if (mode == 3 || mode == 4) begin
			exu_ready_i = 1'b1;
			lsu_wd_i    = 1'b1;
		end
		if (mode == 3) begin
			lsu_mem_to_reg_i = 1'b1;
			lsu_valid_i      = 3'($random(seed)) == 3'd0;
		end
		if (mode == 4) lsu_valid_i = 2'($random(seed)) != 2'd0;
	endtask

	task automatic expect_zero(input string name, input logic [31:0] value);
		if (value !== 32'h0) begin
			tb_errors++;
			$display("** Error %s: got %h, expected %h after reset", name, value, 32'h0);
		end
	endtask

	task automatic run_test(input int num, input string name, input int mode, input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			drive_inputs(mode);
		end
		$display("test %0d %s: %0d cycles, errors so far %0d", num, name, cycles,
			tb_errors + u_checker.errors);
	endtask

	initial begin
		seed      = 32'h758b_3fbe;
		clock     = 1'b0;
		reset     = 1'b1;
		tb_errors = 0;
		clear_inputs();
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		expect_zero("conflict_reg0_o", conflict_reg0_o);
		expect_zero("conflict_reg1_o", conflict_reg1_o);
		expect_zero("conflict_csr_o", conflict_csr_o);
		expect_zero("conflict_id_nop_o", conflict_id_nop_o);
		expect_zero("conflict_reg_bypass_data_o", conflict_reg_bypass_data_o);
		expect_zero("conflict_csr_bypass_data_o", conflict_csr_bypass_data_o);
		expect_zero("stall_events_o", stall_events_o);
		expect_zero("stall_cycles_o", stall_cycles_o);
		reset = 1'b0;
		$display("test 0 reset state: errors so far %0d", tb_errors);
		run_test(1, "register conflicts", 1, REG_CYCLES);
		run_test(2, "csr conflicts", 2, CSR_CYCLES);
		run_test(3, "load wait", 3, LOAD_CYCLES);
		run_test(4, "non-load forwarding", 4, FWD_CYCLES);
		run_test(5, "statistics", 5, STAT_CYCLES);
		@(negedge clock);
		clear_inputs();
		$display("stall events %0d, stall cycles %0d", stall_events_o, stall_cycles_o);
		total = tb_errors + u_checker.errors;
		$display("checks %0d, errors %0d", u_checker.checks + 8, total);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
